// File: design/key_event_fifo.sv
module key_event_fifo (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       event_valid,
    input  logic [7:0] event_ascii,
    input  logic [7:0] event_code,
    input  logic       event_ext,
    input  logic       event_release,
    input  logic       nextdata_n,
    output logic       ready,
    output logic       overflow,
    output logic [7:0] ascii,
    output logic [7:0] key_code,
    output logic       extended,
    output logic       released
);
    import ps2_kbd_pkg::*;

    logic [EVENT_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;          // one extra bit to tell full from empty
    logic               full;
    logic               push;
    logic               pop;
    logic [EVENT_W-1:0] head;

    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign ready = (count != '0);
    assign push  = event_valid && !full;    // full queue drops the event
    assign pop   = ready && !nextdata_n;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {event_ascii, event_code, event_ext, event_release};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
            if (event_valid && full) begin
                overflow <= 1'b1;               // held until reset
            end
        end
    end

    // oldest entry always on the outputs
    assign head     = mem[rd_ptr];
    assign ascii    = head[17:10];
    assign key_code = head[9:2];
    assign extended = head[1];
    assign released = head[0];

endmodule

// File: design/ps2_frame_rx.sv
module ps2_frame_rx (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] code,
    output logic       code_valid,
    output logic       frame_error
);
    import ps2_kbd_pkg::*;

    localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 1);

    logic [2:0] clk_sync;       // ps2_clk synchroniser
    logic [1:0] data_sync;      // matches clk_sync[1] delay
    logic       fall;
    logic       data_bit;
    logic [9:0] buffer;         // start, data, parity
    logic [3:0] bit_cnt;
    logic       last_bit;
    logic       start_ok;
    logic       stop_ok;
    logic       parity_ok;
    logic       frame_ok;

    // both lines idle high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= 3'b111;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign fall     = clk_sync[2] & ~clk_sync[1];   // device drives data before falling
    assign data_bit = data_sync[1];
    assign last_bit = fall && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= 4'd0;
            buffer  <= 10'd0;
        end else if (fall) begin
            if (bit_cnt == LAST_BIT) begin
                bit_cnt <= 4'd0;                    // stop bit, ready for next frame
            end else begin
                buffer[bit_cnt] <= data_bit;
                bit_cnt         <= bit_cnt + 4'd1;
            end
        end
    end

    // stop bit is checked straight off the line
    assign start_ok  = !buffer[0];
    assign stop_ok   = data_bit;
    assign parity_ok = ^buffer[9:1];                // odd over data and parity
    assign frame_ok  = start_ok && stop_ok && parity_ok;

    assign code        = buffer[8:1];
    assign code_valid  = last_bit && frame_ok;
    assign frame_error = last_bit && !frame_ok;

endmodule

// File: design/ps2_kbd_pkg.sv
package ps2_kbd_pkg;

    localparam int FRAME_BITS = 11;           // start, 8 data, parity, stop
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = 3;

    localparam logic [7:0] CODE_BREAK  = 8'hF0;
    localparam logic [7:0] CODE_EXT    = 8'hE0;
    localparam logic [7:0] CODE_LSHIFT = 8'h12;
    localparam logic [7:0] CODE_RSHIFT = 8'h59;

    // ascii, code, extended flag, release flag
    localparam int EVENT_W = 18;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_BREAK,
        DEC_EXT,
        DEC_EXT_BREAK
    } dec_state_t;

    // scan-code set 2, unknown codes give 00
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code, input logic shift);
        logic [7:0] letter;
        letter = 8'h00;
        case (code)
            8'h1C: letter = "a";
            8'h32: letter = "b";
            8'h21: letter = "c";
            8'h23: letter = "d";
            8'h24: letter = "e";
            8'h2B: letter = "f";
            8'h34: letter = "g";
            8'h33: letter = "h";
            8'h43: letter = "i";
            8'h3B: letter = "j";
            8'h42: letter = "k";
            8'h4B: letter = "l";
            8'h3A: letter = "m";
            8'h31: letter = "n";
            8'h44: letter = "o";
            8'h4D: letter = "p";
            8'h15: letter = "q";
            8'h2D: letter = "r";
            8'h1B: letter = "s";
            8'h2C: letter = "t";
            8'h3C: letter = "u";
            8'h2A: letter = "v";
            8'h1D: letter = "w";
            8'h22: letter = "x";
            8'h35: letter = "y";
            8'h1A: letter = "z";
            default: letter = 8'h00;
        endcase
        if (letter != 8'h00) begin
            return shift ? letter - 8'h20 : letter;   // upper case is 20 below
        end
        case (code)
            8'h45: return shift ? ")" : "0";
            8'h16: return shift ? "!" : "1";
            8'h1E: return shift ? "@" : "2";
            8'h26: return shift ? "#" : "3";
            8'h25: return shift ? "$" : "4";
            8'h2E: return shift ? "%" : "5";
            8'h36: return shift ? "^" : "6";
            8'h3D: return shift ? "&" : "7";
            8'h3E: return shift ? "*" : "8";
            8'h46: return shift ? "(" : "9";
            8'h4E: return shift ? "_" : "-";
            8'h55: return shift ? "+" : "=";
            8'h29: return " ";
            8'h5A: return 8'h0D;                  // enter
            8'h66: return 8'h08;                  // backspace
            8'h0D: return 8'h09;                  // tab
            default: return 8'h00;
        endcase
    endfunction

endpackage

// File: design/ps2_keyboard_top.sv
module ps2_keyboard_top (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       nextdata_n,
    output logic [7:0] ascii,
    output logic [7:0] key_code,
    output logic       extended,
    output logic       released,
    output logic       ready,
    output logic       overflow,
    output logic       frame_error
);

    logic [7:0] code;
    logic       code_valid;
    logic       event_valid;
    logic [7:0] event_ascii;
    logic [7:0] event_code;
    logic       event_ext;
    logic       event_release;

    ps2_frame_rx ps2_frame_rx_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .code        (code),
        .code_valid  (code_valid),
        .frame_error (frame_error)
    );

    scan_decoder scan_decoder_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .code          (code),
        .code_valid    (code_valid),
        .event_valid   (event_valid),
        .event_ascii   (event_ascii),
        .event_code    (event_code),
        .event_ext     (event_ext),
        .event_release (event_release)
    );

    key_event_fifo key_event_fifo_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .event_valid   (event_valid),
        .event_ascii   (event_ascii),
        .event_code    (event_code),
        .event_ext     (event_ext),
        .event_release (event_release),
        .nextdata_n    (nextdata_n),
        .ready         (ready),
        .overflow      (overflow),
        .ascii         (ascii),
        .key_code      (key_code),
        .extended      (extended),
        .released      (released)
    );

endmodule

// File: design/scan_decoder.sv
module scan_decoder (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] code,
    input  logic       code_valid,
    output logic       event_valid,
    output logic [7:0] event_ascii,
    output logic [7:0] event_code,
    output logic       event_ext,
    output logic       event_release
);
    import ps2_kbd_pkg::*;

    dec_state_t state;
    logic       lshift;
    logic       rshift;
    logic       shift_held;
    logic       in_ext;
    logic       in_break;
    logic       is_prefix;
    logic       is_shift;
    logic       emit;

    assign in_ext     = (state == DEC_EXT) || (state == DEC_EXT_BREAK);
    assign in_break   = (state == DEC_BREAK) || (state == DEC_EXT_BREAK);
    assign is_prefix  = (code == CODE_EXT) || (code == CODE_BREAK);
    assign shift_held = lshift | rshift;

    // extended 12 is part of print screen, not a shift key
    assign is_shift = !in_ext && ((code == CODE_LSHIFT) || (code == CODE_RSHIFT));
    assign emit     = code_valid && !is_prefix && !is_shift;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DEC_IDLE;
        end else if (code_valid) begin
            case (code)
                CODE_EXT:   state <= DEC_EXT;
                CODE_BREAK: state <= in_ext ? DEC_EXT_BREAK : DEC_BREAK;
                default:    state <= DEC_IDLE;      // key code ends the sequence
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lshift <= 1'b0;
            rshift <= 1'b0;
        end else if (code_valid && is_shift) begin
            if (code == CODE_LSHIFT) begin
                lshift <= !in_break;
            end
            if (code == CODE_RSHIFT) begin
                rshift <= !in_break;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            event_valid   <= 1'b0;
            event_ascii   <= 8'h00;
            event_code    <= 8'h00;
            event_ext     <= 1'b0;
            event_release <= 1'b0;
        end else begin
            event_valid <= emit;
            if (emit) begin
                event_code    <= code;
                event_ext     <= in_ext;
                event_release <= in_break;
                event_ascii   <= in_ext ? 8'h00 : scan_to_ascii(code, shift_held);
            end
        end
    end

endmodule

// File: files.f
design/ps2_kbd_pkg.sv
design/ps2_frame_rx.sv
design/scan_decoder.sv
design/key_event_fifo.sv
design/ps2_keyboard_top.sv
testbench/tb_ps2_keyboard.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_ps2_keyboard \
    -o sim_ps2_keyboard &&
./obj_dir/sim_ps2_keyboard | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: testbench/tb_ps2_keyboard.sv
module tb_ps2_keyboard;

    localparam int N_KEYS     = 24;
    localparam int RAND_KEYS  = 200;
    localparam int FRAME_TIME = 11 * 20 * 100;          // 11 bits, 20 clk per bit, period 100
    localparam int MAX_FRAMES = 60 + RAND_KEYS * 6;     // a shifted random key is 6 frames
    localparam int WATCHDOG   = MAX_FRAMES * FRAME_TIME + 200_000;

    localparam logic [7:0] SC_EXT    = 8'hE0;
    localparam logic [7:0] SC_BREAK  = 8'hF0;
    localparam logic [7:0] SC_LSHIFT = 8'h12;
    localparam logic [7:0] SC_RSHIFT = 8'h59;

    // set 2 codes of the keys the testbench sends, with their characters
    localparam logic [7:0] KEY_CODE [N_KEYS] = '{
        8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h3B, 8'h42, 8'h4B, 8'h15,
        8'h1D, 8'h24, 8'h2D, 8'h1A, 8'h16, 8'h1E, 8'h26, 8'h25,
        8'h2E, 8'h45, 8'h4E, 8'h55, 8'h29, 8'h5A, 8'h66, 8'h0D
    };
    localparam logic [7:0] KEY_LOWER [N_KEYS] = '{
        8'h61, 8'h73, 8'h64, 8'h66, 8'h6A, 8'h6B, 8'h6C, 8'h71,
        8'h77, 8'h65, 8'h72, 8'h7A, 8'h31, 8'h32, 8'h33, 8'h34,
        8'h35, 8'h30, 8'h2D, 8'h3D, 8'h20, 8'h0D, 8'h08, 8'h09
    };
    localparam logic [7:0] KEY_UPPER [N_KEYS] = '{
        8'h41, 8'h53, 8'h44, 8'h46, 8'h4A, 8'h4B, 8'h4C, 8'h51,
        8'h57, 8'h45, 8'h52, 8'h5A, 8'h21, 8'h40, 8'h23, 8'h24,
        8'h25, 8'h29, 8'h5F, 8'h2B, 8'h20, 8'h0D, 8'h08, 8'h09
    };

    logic       clk = 1'b0;
    logic       arst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       nextdata_n = 1'b1;
    logic [7:0] ascii;
    logic [7:0] key_code;
    logic       extended;
    logic       released;
    logic       ready;
    logic       overflow;
    logic       frame_error;

    logic [17:0] exp_q [$];     // ascii, code, ext, release
    logic [17:0] exp_ev;
    logic        ref_ext;
    logic        ref_brk;
    logic        ref_lshift;
    logic        ref_rshift;
    logic        pop_enable;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          fe_count = 0;
    int          exp_fe = 0;
    int          idx;
    int          sel;
    string       test_name = "reset";

    ps2_keyboard_top ps2_keyboard_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .nextdata_n  (nextdata_n),
        .ascii       (ascii),
        .key_code    (key_code),
        .extended    (extended),
        .released    (released),
        .ready       (ready),
        .overflow    (overflow),
        .frame_error (frame_error)
    );

    always #50 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic logic [7:0] ref_ascii(input logic [7:0] c, input logic shift);
        for (int i = 0; i < N_KEYS; i++) begin
            if (KEY_CODE[i] == c) begin
                return shift ? KEY_UPPER[i] : KEY_LOWER[i];
            end
        end
        return 8'h00;           // not in table
    endfunction

    // decoder rules applied to each received code
    function automatic void model_code(input logic [7:0] c);
        if (c == SC_EXT) begin
            ref_ext = 1'b1;
            ref_brk = 1'b0;
        end else if (c == SC_BREAK) begin
            ref_brk = 1'b1;     // keeps extended
        end else begin
            if (!ref_ext && c == SC_LSHIFT) begin
                ref_lshift = !ref_brk;
            end else if (!ref_ext && c == SC_RSHIFT) begin
                ref_rshift = !ref_brk;
            end else begin
                exp_q.push_back({ref_ext ? 8'h00 : ref_ascii(c, ref_lshift | ref_rshift),
                                 c, ref_ext, ref_brk});
            end
            ref_ext = 1'b0;
            ref_brk = 1'b0;
        end
    endfunction

    // device sets data up before holding the clock low for 10 of 20 cycles
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        logic        par;
        par  = ~^data;          // odd parity
        if (bad_parity) begin
            par = ~par;
        end
        bits = {1'b1, par, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data <= bits[i];
            repeat (5) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (10) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (4) @(posedge clk);
        end
    endtask

    task automatic send_code(input logic [7:0] c);
        model_code(c);
        send_frame(c, 1'b0);
    endtask

    // sel 0 plain, 1 left shift, 2 right shift
    task automatic tap_key(input int key, input int shift_sel);
        logic [7:0] sc;
        sc = (shift_sel == 1) ? SC_LSHIFT : SC_RSHIFT;
        if (shift_sel != 0) begin
            send_code(sc);
        end
        send_code(KEY_CODE[key]);
        send_code(SC_BREAK);
        send_code(KEY_CODE[key]);
        if (shift_sel != 0) begin
            send_code(SC_BREAK);
            send_code(sc);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || ready) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (arst_n && frame_error) begin
            fe_count++;
        end
    end

    // pops on random cycles and compares the oldest event
    always @(posedge clk) begin
        if (arst_n) begin
            if (!nextdata_n && ready) begin
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("Error: %s gave an event with code %0h that was not expected",
                             test_name, key_code);
                end else begin
                    exp_ev = exp_q.pop_front();
                    compare_value({test_name, " ascii"}, 32'(exp_ev[17:10]), 32'(ascii));
                    compare_value({test_name, " key_code"}, 32'(exp_ev[9:2]), 32'(key_code));
                    compare_value({test_name, " extended"}, 32'(exp_ev[1]), 32'(extended));
                    compare_value({test_name, " released"}, 32'(exp_ev[0]), 32'(released));
                end
            end
            nextdata_n <= !(pop_enable && ready && nextdata_n && ($urandom_range(1) == 0));
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Error: simulation timed out during test %s", test_name);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(76935));
        arst_n     = 1'b0;
        ps2_clk    = 1'b1;      // bus idles high
        ps2_data   = 1'b1;
        pop_enable = 1'b1;
        ref_ext    = 1'b0;
        ref_brk    = 1'b0;
        ref_lshift = 1'b0;
        ref_rshift = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);

        test_name = "reset";
        compare_value({test_name, " ready"}, 32'd0, 32'(ready));
        compare_value({test_name, " overflow"}, 32'd0, 32'(overflow));
        tap_key(0, 0);          // a make, a break
        wait_drained();

        test_name = "shift";
        send_code(SC_LSHIFT);
        send_code(KEY_CODE[0]);
        send_code(SC_BREAK);
        send_code(SC_LSHIFT);
        send_code(KEY_CODE[0]);
        send_code(SC_RSHIFT);
        send_code(KEY_CODE[12]);
        send_code(SC_BREAK);
        send_code(SC_RSHIFT);
        send_code(KEY_CODE[12]);
        wait_drained();

        test_name = "extended";
        send_code(SC_EXT);
        send_code(8'h75);
        send_code(SC_EXT);
        send_code(SC_BREAK);
        send_code(8'h75);
        wait_drained();

        test_name = "parity";
        send_frame(KEY_CODE[0], 1'b1);
        exp_fe++;
        tap_key(1, 0);
        wait_drained();
        compare_value({test_name, " frame_error count"}, 32'(exp_fe), 32'(fe_count));

        test_name = "overflow";
        @(posedge clk);
        pop_enable <= 1'b0;
        for (int i = 0; i < 10; i++) begin
            send_code(KEY_CODE[i]);
        end
        void'(exp_q.pop_back());    // last two never fit
        void'(exp_q.pop_back());
        compare_value({test_name, " ready"}, 32'd1, 32'(ready));
        compare_value({test_name, " overflow"}, 32'd1, 32'(overflow));
        pop_enable <= 1'b1;
        wait_drained();
        compare_value({test_name, " overflow after drain"}, 32'd1, 32'(overflow));

        test_name = "random";
        for (int n = 0; n < RAND_KEYS; n++) begin
            idx = int'($urandom_range(N_KEYS - 1));
            sel = int'($urandom_range(3));
            tap_key(idx, (sel > 2) ? 0 : sel);
        end
        wait_drained();
        compare_value({test_name, " frame_error count"}, 32'(exp_fe), 32'(fe_count));

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
